//--- rgmii_phy_bridge.f
verilog/gmii_line_pkg.sv
verilog/rgmii_csr_pkg.sv
verilog/rgmii_tx_encoder.sv
verilog/rgmii_rx_decoder.sv
verilog/rgmii_link_monitor.sv
verilog/rgmii_phy_bridge.sv
dv/rgmii_phy_bridge_tb.sv

//--- Makefile
TOP = rgmii_phy_bridge_tb
LOG = sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing -Wno-fatal -f rgmii_phy_bridge.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

lint:
	verilator --lint-only -Wall $(shell grep '^verilog/' rgmii_phy_bridge.f) --top-module rgmii_phy_bridge

clean:
	rm -rf obj_dir $(LOG)

//--- dv/rgmii_phy_bridge_tb.sv
`timescale 1ns/10ps

module rgmii_phy_bridge_tb
    import gmii_line_pkg::*;
    import rgmii_csr_pkg::*;
();

    localparam int RAND_CYCLES = 300;
    // random phase plus frames and register traffic
    localparam int TEST_CYCLES = RAND_CYCLES + 600;
    localparam int TX_FRAMES   = 5;
    localparam int RX_FRAMES   = 6;
    localparam int RX_ERR      = 2;

    logic                  clk;
    logic                  rst_n;
    gmii_tx_t              gmii_tx;
    rgmii_ddr_t            rgmii_tx;
    rgmii_ddr_t            rgmii_rx;
    gmii_rx_t              gmii_rx;
    axil_req_t             csr_req;
    axil_rsp_t             csr_rsp;
    gmii_tx_t              tx_prev;
    rgmii_ddr_t            rx_prev;
    logic                  chk_en;
    rgmii_inband_t         cur_status;
    logic [31:0]           rnd_word;
    int                    line_errors;
    int                    reg_errors;
    int                    i;
    int                    n;

    rgmii_phy_bridge rgmii_phy_bridge_inst (
        .gmii_clk_i (clk),
        .rst_n_i    (rst_n),
        .gmii_tx_i  (gmii_tx),
        .rgmii_tx_o (rgmii_tx),
        .rgmii_rx_i (rgmii_rx),
        .gmii_rx_o  (gmii_rx),
        .csr_req_i  (csr_req),
        .csr_rsp_o  (csr_rsp)
    );

    // 8 ns clock
    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // expected tx pins for one gmii byte
    function automatic rgmii_ddr_t ref_tx(input gmii_tx_t t);
        rgmii_ddr_t r;
        r.d_rise   = t.data[3:0];
        r.d_fall   = t.data[7:4];
        r.ctl_rise = t.en;
        r.ctl_fall = t.en ^ t.er;
        return r;
    endfunction

    // expected gmii byte for one rgmii cycle
    function automatic gmii_rx_t ref_rx(input rgmii_ddr_t r);
        gmii_rx_t g;
        g.data = {r.d_fall, r.d_rise};
        g.dv   = r.ctl_rise;
        g.er   = r.ctl_rise ^ r.ctl_fall;
        return g;
    endfunction

    // 32-bit counter value that wraps after a number of frame ends
    function automatic logic [CSR_DATA_W-1:0] ref_count(input logic [CSR_DATA_W-1:0] base,
                                                        input logic [CSR_DATA_W-1:0] frames);
        return base + frames;
    endfunction

    task automatic compare_ddr(input string name, input rgmii_ddr_t got, input rgmii_ddr_t exp);
        if (got !== exp)
        begin
            $display("Fail %s got 0x%h exp 0x%h", name, got, exp);
            line_errors++;
        end
    endtask

    task automatic compare_gmii_rx(input string name, input gmii_rx_t got, input gmii_rx_t exp);
        if (got !== exp)
        begin
            $display("Fail %s got 0x%h exp 0x%h", name, got, exp);
            line_errors++;
        end
    endtask

    task automatic compare_word(input string name, input logic [CSR_DATA_W-1:0] got,
                                input logic [CSR_DATA_W-1:0] exp);
        if (got !== exp)
        begin
            $display("Fail %s got 0x%h exp 0x%h", name, got, exp);
            reg_errors++;
        end
    endtask

    // one write and its response with bready held high
    task automatic write_reg(input logic [CSR_ADDR_W-1:0] addr,
                             input logic [CSR_DATA_W-1:0] data, input logic [1:0] exp_resp);
        int waited;
        @(negedge clk);
        csr_req.awvalid = 1'b1;
        csr_req.awaddr  = addr;
        csr_req.wvalid  = 1'b1;
        csr_req.wdata   = data;
        csr_req.wstrb   = '1;
        waited = 0;
        do
        begin
            @(negedge clk);
            waited++;
        end
        while (!csr_rsp.bvalid && waited < 20);
        csr_req.awvalid = 1'b0;
        csr_req.wvalid  = 1'b0;
        if (!csr_rsp.bvalid)
        begin
            $display("write to 0x%h got no response", addr);
            reg_errors++;
        end
        compare_word($sformatf("bresp[0x%h]", addr), 32'(csr_rsp.bresp), 32'(exp_resp));
    endtask

    // one read with data and response checked
    task automatic read_reg(input logic [CSR_ADDR_W-1:0] addr,
                            input logic [CSR_DATA_W-1:0] exp_data, input logic [1:0] exp_resp);
        int waited;
        @(negedge clk);
        csr_req.arvalid = 1'b1;
        csr_req.araddr  = addr;
        waited = 0;
        do
        begin
            @(negedge clk);
            waited++;
        end
        while (!csr_rsp.rvalid && waited < 20);
        csr_req.arvalid = 1'b0;
        if (!csr_rsp.rvalid)
        begin
            $display("read of 0x%h got no response", addr);
            reg_errors++;
        end
        compare_word($sformatf("rdata[0x%h]", addr), csr_rsp.rdata, exp_data);
        compare_word($sformatf("rresp[0x%h]", addr), 32'(csr_rsp.rresp), 32'(exp_resp));
    endtask

    // inter-frame cycle with status on the low nibble
    task automatic drive_rx_idle(input rgmii_inband_t st);
        rgmii_rx.d_rise   = st;
        rgmii_rx.d_fall   = 4'h0;
        rgmii_rx.ctl_rise = 1'b0;
        rgmii_rx.ctl_fall = 1'b0;
    endtask

    task automatic send_tx_frame(input int len);
        logic [31:0] rnd;
        repeat (len)
        begin
            @(negedge clk);
            rnd = $urandom;
            gmii_tx.data = rnd[7:0];
            gmii_tx.er   = rnd[8];
            gmii_tx.en   = 1'b1;
        end
        // one low cycle marks the frame end
        @(negedge clk);
        gmii_tx = '0;
    endtask

    task automatic send_rx_frame(input int len, input logic with_err);
        logic [31:0] rnd;
        int          k;
        for (k = 0; k < len; k++)
        begin
            @(negedge clk);
            rnd = $urandom;
            rgmii_rx.d_rise   = rnd[3:0];
            rgmii_rx.d_fall   = rnd[7:4];
            rgmii_rx.ctl_rise = 1'b1;
            // error shows as a low fall half mid frame
            rgmii_rx.ctl_fall = !(with_err && k == len / 2);
        end
        @(negedge clk);
        drive_rx_idle(cur_status);
    endtask

    // inputs delayed by one cycle for the line compare
    always @(posedge clk)
    begin
        tx_prev <= gmii_tx;
        rx_prev <= rgmii_rx;
        chk_en  <= rst_n;
    end

    // line outputs checked on every falling edge
    always @(negedge clk)
    begin
        if (chk_en)
        begin
            compare_ddr("rgmii_tx_o", rgmii_tx, ref_tx(tx_prev));
            compare_gmii_rx("gmii_rx_o", gmii_rx, ref_rx(rx_prev));
        end
    end

    initial
    begin
        void'($urandom(32'h3f24c8c8));
        line_errors    = 0;
        reg_errors     = 0;
        rst_n          = 1'b0;
        gmii_tx        = '0;
        cur_status     = '0;
        drive_rx_idle(cur_status);
        csr_req        = '0;
        csr_req.bready = 1'b1;
        csr_req.rready = 1'b1;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        // random traffic both ways
        repeat (RAND_CYCLES)
        begin
            @(negedge clk);
            rnd_word = $urandom;
            gmii_tx  = rnd_word[9:0];
            rgmii_rx = rnd_word[19:10];
        end
        @(negedge clk);
        gmii_tx = '0;

        // link up at gigabit full duplex and then at 100M half duplex
        cur_status.link_up     = 1'b1;
        cur_status.speed       = SPEED_1000;
        cur_status.full_duplex = 1'b1;
        drive_rx_idle(cur_status);
        repeat (3) @(negedge clk);
        read_reg(REG_STATUS, {28'h0, cur_status}, RESP_OKAY);
        cur_status.speed       = SPEED_100;
        cur_status.full_duplex = 1'b0;
        drive_rx_idle(cur_status);
        repeat (3) @(negedge clk);
        read_reg(REG_STATUS, {28'h0, cur_status}, RESP_OKAY);
        // status must hold while a frame is running
        // low nibble of the data byte differs from the held status
        @(negedge clk);
        rnd_word = $urandom;
        rgmii_rx = {4'(~cur_status), rnd_word[3:0], 2'b11};
        read_reg(REG_STATUS, {28'h0, cur_status}, RESP_OKAY);
        @(negedge clk);
        drive_rx_idle(cur_status);

        // frame counts from a cleared start
        repeat (4) @(negedge clk);
        write_reg(REG_CTRL, 32'h1, RESP_OKAY);
        for (i = 0; i < TX_FRAMES; i++)
            send_tx_frame(2 + i);
        for (i = 0; i < RX_FRAMES; i++)
            send_rx_frame(3 + i % 3, i < RX_ERR);
        repeat (4) @(negedge clk);
        read_reg(REG_TX_FRAMES, ref_count(32'h0, TX_FRAMES), RESP_OKAY);
        read_reg(REG_RX_FRAMES, ref_count(32'h0, RX_FRAMES), RESP_OKAY);
        read_reg(REG_RX_ERR_FRAMES, ref_count(32'h0, RX_ERR), RESP_OKAY);

        // back-pressure on b and r
        @(negedge clk);
        csr_req.bready  = 1'b0;
        csr_req.rready  = 1'b0;
        csr_req.awvalid = 1'b1;
        csr_req.awaddr  = REG_CTRL;
        csr_req.wvalid  = 1'b1;
        csr_req.wdata   = '0;
        csr_req.arvalid = 1'b1;
        csr_req.araddr  = REG_RX_FRAMES;
        n = 0;
        do
        begin
            @(negedge clk);
            n++;
        end
        while (!(csr_rsp.bvalid && csr_rsp.rvalid) && n < 20);
        // second requests answer slverr if they are ever taken
        csr_req.awaddr = REG_STATUS;
        csr_req.araddr = 8'h40;
        repeat (4)
        begin
            @(negedge clk);
            compare_word("bvalid rvalid awready wready arready",
                         {27'h0, csr_rsp.bvalid, csr_rsp.rvalid, csr_rsp.awready,
                          csr_rsp.wready, csr_rsp.arready}, 32'h18);
            compare_word("rdata held", csr_rsp.rdata, ref_count(32'h0, RX_FRAMES));
            compare_word("bresp rresp held", {28'h0, csr_rsp.bresp, csr_rsp.rresp}, 32'h0);
        end
        csr_req.awvalid = 1'b0;
        csr_req.wvalid  = 1'b0;
        csr_req.arvalid = 1'b0;
        csr_req.bready  = 1'b1;
        csr_req.rready  = 1'b1;
        @(negedge clk);
        compare_word("bvalid rvalid taken", {30'h0, csr_rsp.bvalid, csr_rsp.rvalid}, 32'h0);

        // clear, read-only write, unmapped read
        write_reg(REG_CTRL, 32'h1, RESP_OKAY);
        read_reg(REG_TX_FRAMES, 32'h0, RESP_OKAY);
        read_reg(REG_RX_FRAMES, 32'h0, RESP_OKAY);
        read_reg(REG_RX_ERR_FRAMES, 32'h0, RESP_OKAY);
        read_reg(REG_CTRL, 32'h0, RESP_OKAY);
        write_reg(REG_TX_FRAMES, 32'h5, RESP_SLVERR);
        read_reg(8'h20, 32'h0, RESP_SLVERR);

        repeat (4) @(negedge clk);
        $display("errors: line %0d, register %0d", line_errors, reg_errors);
        if (line_errors == 0 && reg_errors == 0)
        begin
            $display("TEST PASS");
        end
        else
        begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // run length bound from all phases plus margin
    initial
    begin
        #(TEST_CYCLES * 8 + 2000);
        $display("watchdog expired, run did not finish in %0d ns", TEST_CYCLES * 8 + 2000);
        $display("errors: line %0d, register %0d", line_errors, reg_errors);
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- verilog/rgmii_phy_bridge.sv
`timescale 1ns/10ps

module rgmii_phy_bridge
    import gmii_line_pkg::*;
    import rgmii_csr_pkg::*;
(
    input  logic       gmii_clk_i,
    input  logic       rst_n_i,
    // mac transmit side in, phy transmit pins out
    input  gmii_tx_t   gmii_tx_i,
    output rgmii_ddr_t rgmii_tx_o,
    // phy receive pins in, mac receive side out
    input  rgmii_ddr_t rgmii_rx_i,
    output gmii_rx_t   gmii_rx_o,
    // register access
    input  axil_req_t  csr_req_i,
    output axil_rsp_t  csr_rsp_o
);

    // latched link status from the rx path
    rgmii_inband_t inband_w;

    // tx path, mac byte to rgmii cycle
    rgmii_tx_encoder rgmii_tx_encoder_inst (
        .gmii_clk_i (gmii_clk_i),
        .rst_n_i    (rst_n_i),
        .gmii_tx_i  (gmii_tx_i),
        .rgmii_tx_o (rgmii_tx_o)
    );

    // rx path, rgmii cycle to mac byte plus status
    rgmii_rx_decoder rgmii_rx_decoder_inst (
        .gmii_clk_i (gmii_clk_i),
        .rst_n_i    (rst_n_i),
        .rgmii_rx_i (rgmii_rx_i),
        .gmii_rx_o  (gmii_rx_o),
        .inband_o   (inband_w)
    );

    // monitor taps the raw tx input and the decoded rx output
    rgmii_link_monitor rgmii_link_monitor_inst (
        .gmii_clk_i (gmii_clk_i),
        .rst_n_i    (rst_n_i),
        .gmii_tx_i  (gmii_tx_i),
        .gmii_rx_i  (gmii_rx_o),
        .inband_i   (inband_w),
        .csr_req_i  (csr_req_i),
        .csr_rsp_o  (csr_rsp_o)
    );

endmodule

//--- verilog/rgmii_link_monitor.sv
`timescale 1ns/10ps

module rgmii_link_monitor
    import gmii_line_pkg::*;
    import rgmii_csr_pkg::*;
(
    input  logic          gmii_clk_i,
    input  logic          rst_n_i,
    input  gmii_tx_t      gmii_tx_i,
    input  gmii_rx_t      gmii_rx_i,
    input  rgmii_inband_t inband_i,
    input  axil_req_t     csr_req_i,
    output axil_rsp_t     csr_rsp_o
);

    logic                  tx_en_d1;
    logic                  tx_en_d2;
    logic                  tx_end;
    logic                  rx_dv_d1;
    logic                  rx_end;
    logic                  rx_err_seen;
    rgmii_inband_t         status_q;
    logic [CSR_DATA_W-1:0] tx_frames;
    logic [CSR_DATA_W-1:0] rx_frames;
    logic [CSR_DATA_W-1:0] rx_err_frames;
    logic                  wr_fire;
    logic                  rd_fire;
    logic                  cnt_clear;
    logic                  b_valid_q;
    logic [1:0]            b_resp_q;
    logic                  r_valid_q;
    logic [CSR_DATA_W-1:0] r_data_q;
    logic [1:0]            r_resp_q;
    logic [CSR_DATA_W-1:0] rd_data;
    logic [1:0]            rd_resp;

    // tx frame end, seen one cycle after en drops
    assign tx_end = tx_en_d2 & ~tx_en_d1;
    // rx frame end on the falling edge of decoded dv
    assign rx_end = rx_dv_d1 & ~gmii_rx_i.dv;

    // aw and w taken together, only with no b pending
    assign wr_fire   = csr_req_i.awvalid & csr_req_i.wvalid & ~b_valid_q;
    assign rd_fire   = csr_req_i.arvalid & ~r_valid_q;
    // counter clear from bit 0 of ctrl
    assign cnt_clear = wr_fire && (csr_req_i.awaddr == REG_CTRL) &&
                       csr_req_i.wstrb[0] && csr_req_i.wdata[0];

    always_ff @(posedge gmii_clk_i)
    begin
        if (!rst_n_i)
        begin
            tx_en_d1      <= 1'b0;
            tx_en_d2      <= 1'b0;
            rx_dv_d1      <= 1'b0;
            rx_err_seen   <= 1'b0;
            status_q      <= '0;
            tx_frames     <= '0;
            rx_frames     <= '0;
            rx_err_frames <= '0;
        end
        else
        begin
            tx_en_d1 <= gmii_tx_i.en;
            tx_en_d2 <= tx_en_d1;
            rx_dv_d1 <= gmii_rx_i.dv;
            status_q <= inband_i;
            // sticky error for the frame in flight
            if (rx_end)
                rx_err_seen <= 1'b0;
            else if (gmii_rx_i.dv && gmii_rx_i.er)
                rx_err_seen <= 1'b1;
            // clear beats a frame end in the same cycle
            if (cnt_clear)
            begin
                tx_frames     <= '0;
                rx_frames     <= '0;
                rx_err_frames <= '0;
            end
            else
            begin
                if (tx_end)
                    tx_frames <= tx_frames + 1'b1;
                if (rx_end)
                    rx_frames <= rx_frames + 1'b1;
                if (rx_end && rx_err_seen)
                    rx_err_frames <= rx_err_frames + 1'b1;
            end
        end
    end

    // read mux against the register map
    always_comb
    begin
        rd_data = '0;
        rd_resp = RESP_OKAY;
        case (csr_req_i.araddr)
            REG_STATUS:        rd_data = {{(CSR_DATA_W-4){1'b0}}, status_q};
            REG_TX_FRAMES:     rd_data = tx_frames;
            REG_RX_FRAMES:     rd_data = rx_frames;
            REG_RX_ERR_FRAMES: rd_data = rx_err_frames;
            // ctrl is write-only, reads as zero
            REG_CTRL:          rd_data = '0;
            default:           rd_resp = RESP_SLVERR;
        endcase
    end

    // response channels, held until the master takes them
    always_ff @(posedge gmii_clk_i)
    begin
        if (!rst_n_i)
        begin
            b_valid_q <= 1'b0;
            b_resp_q  <= RESP_OKAY;
            r_valid_q <= 1'b0;
            r_data_q  <= '0;
            r_resp_q  <= RESP_OKAY;
        end
        else
        begin
            if (wr_fire)
            begin
                b_valid_q <= 1'b1;
                // only ctrl is writable
                b_resp_q  <= (csr_req_i.awaddr == REG_CTRL) ? RESP_OKAY : RESP_SLVERR;
            end
            else if (csr_req_i.bready)
            begin
                b_valid_q <= 1'b0;
            end
            if (rd_fire)
            begin
                r_valid_q <= 1'b1;
                r_data_q  <= rd_data;
                r_resp_q  <= rd_resp;
            end
            else if (csr_req_i.rready)
            begin
                r_valid_q <= 1'b0;
            end
        end
    end

    always_comb
    begin
        csr_rsp_o.awready = wr_fire;
        csr_rsp_o.wready  = wr_fire;
        csr_rsp_o.bvalid  = b_valid_q;
        csr_rsp_o.bresp   = b_resp_q;
        csr_rsp_o.arready = rd_fire;
        csr_rsp_o.rvalid  = r_valid_q;
        csr_rsp_o.rdata   = r_data_q;
        csr_rsp_o.rresp   = r_resp_q;
    end

endmodule

//--- verilog/rgmii_rx_decoder.sv
`timescale 1ns/10ps

module rgmii_rx_decoder
    import gmii_line_pkg::*;
(
    input  logic          gmii_clk_i,
    input  logic          rst_n_i,
    input  rgmii_ddr_t    rgmii_rx_i,
    output gmii_rx_t      gmii_rx_o,
    output rgmii_inband_t inband_o
);

    rx_byte_u rx_byte;
    logic     rx_dv;
    logic     rx_er;

    // join the halves, fall nibble is the upper one
    assign rx_byte.data = {rgmii_rx_i.d_fall, rgmii_rx_i.d_rise};

    // rx_ctl rise is dv, the fall half is dv xor er
    assign rx_dv = rgmii_rx_i.ctl_rise;
    assign rx_er = rgmii_rx_i.ctl_rise ^ rgmii_rx_i.ctl_fall;

    // gmii side register, mirrors the iddr output stage
    always_ff @(posedge gmii_clk_i)
    begin
        if (!rst_n_i)
        begin
            gmii_rx_o <= '0;
        end
        else
        begin
            gmii_rx_o.data <= rx_byte.data;
            gmii_rx_o.dv   <= rx_dv;
            gmii_rx_o.er   <= rx_er;
        end
    end

    // inter-frame cycles carry link status on rxd
    // held between idle cycles
    always_ff @(posedge gmii_clk_i)
    begin
        if (!rst_n_i)
        begin
            // link down out of reset
            inband_o <= '0;
        end
        else if (!rx_dv && !rx_er)
        begin
            inband_o <= rx_byte.inband.status;
        end
    end

endmodule

//--- verilog/rgmii_tx_encoder.sv
`timescale 1ns/10ps

module rgmii_tx_encoder
    import gmii_line_pkg::*;
(
    input  logic       gmii_clk_i,
    input  logic       rst_n_i,
    input  gmii_tx_t   gmii_tx_i,
    output rgmii_ddr_t rgmii_tx_o
);

    // stands in for the output ddr cells
    // one flop stage, rise half and fall half captured together
    always_ff @(posedge gmii_clk_i)
    begin
        if (!rst_n_i)
        begin
            rgmii_tx_o <= '0;
        end
        else
        begin
            // low nibble goes out on the rising edge
            rgmii_tx_o.d_rise   <= gmii_tx_i.data[3:0];
            // high nibble on the falling edge
            rgmii_tx_o.d_fall   <= gmii_tx_i.data[7:4];
            // tx_ctl rise carries tx_en
            rgmii_tx_o.ctl_rise <= gmii_tx_i.en;
            // fall carries en xor er, so er costs no extra pin
            rgmii_tx_o.ctl_fall <= gmii_tx_i.en ^ gmii_tx_i.er;
        end
    end

endmodule

//--- verilog/rgmii_csr_pkg.sv
package rgmii_csr_pkg;

    localparam int CSR_ADDR_W = 8;
    localparam int CSR_DATA_W = 32;

    // register map, byte offsets
    localparam logic [CSR_ADDR_W-1:0] REG_STATUS        = 8'h00;
    localparam logic [CSR_ADDR_W-1:0] REG_TX_FRAMES     = 8'h04;
    localparam logic [CSR_ADDR_W-1:0] REG_RX_FRAMES     = 8'h08;
    localparam logic [CSR_ADDR_W-1:0] REG_RX_ERR_FRAMES = 8'h0C;
    localparam logic [CSR_ADDR_W-1:0] REG_CTRL          = 8'h10;

    // axi response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // master to slave, all five channels
    typedef struct packed {
        logic                    awvalid;
        logic [CSR_ADDR_W-1:0]   awaddr;
        logic                    wvalid;
        logic [CSR_DATA_W-1:0]   wdata;
        logic [CSR_DATA_W/8-1:0] wstrb;
        logic                    bready;
        logic                    arvalid;
        logic [CSR_ADDR_W-1:0]   araddr;
        logic                    rready;
    } axil_req_t;

    // slave to master
    typedef struct packed {
        logic                  awready;
        logic                  wready;
        logic                  bvalid;
        logic [1:0]            bresp;
        logic                  arready;
        logic                  rvalid;
        logic [CSR_DATA_W-1:0] rdata;
        logic [1:0]            rresp;
    } axil_rsp_t;

endpackage

//--- verilog/gmii_line_pkg.sv
package gmii_line_pkg;

    // speed codes carried in the in-band status nibble
    localparam logic [1:0] SPEED_10   = 2'b00;
    localparam logic [1:0] SPEED_100  = 2'b01;
    localparam logic [1:0] SPEED_1000 = 2'b10;

    // gmii transmit side, as driven by the mac
    typedef struct packed {
        logic [7:0] data;
        logic       en;
        logic       er;
    } gmii_tx_t;

    // gmii receive side, as seen by the mac
    typedef struct packed {
        logic [7:0] data;
        logic       dv;
        logic       er;
    } gmii_rx_t;

    // one rgmii cycle, rise and fall halves side by side
    typedef struct packed {
        logic [3:0] d_rise;
        logic [3:0] d_fall;
        logic       ctl_rise;
        logic       ctl_fall;
    } rgmii_ddr_t;

    // in-band status, bit order as on rxd[3:0]
    typedef struct packed {
        logic       full_duplex;
        logic [1:0] speed;
        logic       link_up;
    } rgmii_inband_t;

    // received byte, frame data or in-band status
    typedef union packed {
        logic [7:0] data;
        struct packed {
            logic [3:0]    rsvd;
            rgmii_inband_t status;
        } inband;
    } rx_byte_u;

endpackage
